/* bench/tb_mem_model.sv */
`timescale 1ns/1ns

module tb_mem_model (
  input  logic             clk,
  input  logic             arst_n,
  input  logic             mem_req,
  input  rv_pkg::mem_cmd_t mem_cmd,
  output logic             mem_ack,
  output logic [31:0]      mem_rdata,
  output logic             wr_valid,  // one-cycle write log
  output logic [31:0]      wr_addr,
  output logic [31:0]      wr_data
);

  logic [31:0] mem [256];
  logic [31:0] rng;
  logic        pending;
  int unsigned wait_cnt;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // program half at reset_vector, data half at reset_vector+0x400
  function automatic logic [7:0] word_index(input logic [31:0] addr);
    return {addr[10], addr[8:2]};
  endfunction

  task automatic load_word(input int idx, input logic [31:0] value);
    mem[idx] = value;
  endtask

  initial begin
    for (int i = 0; i < 256; i++) begin
      mem[i] = 32'hc0de_0000 + 32'(i * 32'h0001_0101);
    end
    rng       = 32'h7cf3a5c1;
    pending   = 1'b0;
    wait_cnt  = 0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    wr_valid  = 1'b0;
    wr_addr   = '0;
    wr_data   = '0;
    forever begin
      @(posedge clk);
      #2;
      wr_valid = 1'b0;
      if (!arst_n) begin
        mem_ack = 1'b0;
        pending = 1'b0;
      end else if (mem_ack) begin
        if (!mem_req) mem_ack = 1'b0;  // phase 4
      end else if (mem_req) begin
        if (!pending) begin
          rng      = xorshift(rng);
          wait_cnt = rng % 4;  // 0 to 3 idle cycles
          pending  = 1'b1;
        end
        if (wait_cnt == 0) begin
          pending   = 1'b0;
          mem_ack   = 1'b1;
          mem_rdata = mem[word_index(mem_cmd.addr)];
          if (mem_cmd.write) begin
            mem[word_index(mem_cmd.addr)] = mem_cmd.wdata;
            wr_valid = 1'b1;
            wr_addr  = mem_cmd.addr;
            wr_data  = mem_cmd.wdata;
          end
        end else begin
          wait_cnt--;
        end
      end
    end
  end

endmodule

/* bench/tb_rv_core.sv */
`timescale 1ns/1ns

module tb_rv_core;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] data;
    logic [2:0]  group;
  } store_t;

  logic             clk;
  logic             arst_n;
  logic             mem_req;
  rv_pkg::mem_cmd_t mem_cmd;
  logic             mem_ack;
  logic [31:0]      mem_rdata;
  logic [31:0]      pc;
  logic             wr_valid;
  logic [31:0]      wr_addr;
  logic [31:0]      wr_data;
  logic [64:0]      cmd_bits;
  logic [31:0]      prog [$];
  store_t           expect_q [$];
  int unsigned      data_off;
  int               err_count;
  int               tests_run;
  int               tests_failed;
  int               group_err [7];
  logic             built;

  rv_core u_rv_core (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .pc        (pc)
  );

  tb_mem_model u_mem (
    .clk       (clk),
    .arst_n    (arst_n),
    .mem_req   (mem_req),
    .mem_cmd   (mem_cmd),
    .mem_ack   (mem_ack),
    .mem_rdata (mem_rdata),
    .wr_valid  (wr_valid),
    .wr_addr   (wr_addr),
    .wr_data   (wr_data)
  );

  assign cmd_bits = mem_cmd;

  function automatic string group_title(input int g);
    case (g)
      1: return "reset and fetch start";
      2: return "handshake rules";
      3: return "alu operations";
      4: return "branches";
      5: return "jumps and upper immediates";
      default: return "load after store";
    endcase
  endfunction

  function automatic logic [31:0] cur_pc();
    return 32'h8000_0000 + 32'(prog.size() * 4);
  endfunction

  function automatic void emit(input logic [31:0] w);
    prog.push_back(w);
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [4:0] rs2);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] i_type(input logic [6:0] op, input logic [2:0] f3,
                                         input logic [4:0] rd, input logic [4:0] rs1,
                                         input logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] s_word(input logic [4:0] rs2, input logic [11:0] imm);
    return {imm[11:5], rs2, 5'd10, 3'b010, imm[4:0], 7'b0100011};  // sw rs2, imm(x10)
  endfunction

  function automatic logic [31:0] b_type(input logic [2:0] f3, input logic [4:0] rs1,
                                         input logic [4:0] rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] j_type(input logic [4:0] rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic void store_expected(input logic [4:0] rs, input logic [31:0] value,
                                         input logic [2:0] group);
    emit(s_word(rs, 12'(data_off)));
    expect_q.push_back('{addr: 32'h8000_0400 + data_off, data: value, group: group});
    data_off += 4;
  endfunction

  function automatic void alu_rr(input logic [6:0] f7, input logic [2:0] f3,
                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                 input logic [31:0] value);
    emit(r_type(f7, f3, 5'd4, rs1, rs2));
    store_expected(5'd4, value, 3'd3);
  endfunction

  function automatic void alu_ri(input logic [2:0] f3, input logic [4:0] rs1,
                                 input logic [11:0] imm, input logic [31:0] value);
    emit(i_type(7'b0010011, f3, 5'd4, rs1, imm));
    store_expected(5'd4, value, 3'd3);
  endfunction

  // skipped path stores x6 at the marker address
  function automatic void branch_case(input logic [2:0] f3, input logic [4:0] rs1,
                                      input logic [4:0] rs2, input logic take);
    emit(b_type(f3, rs1, rs2, 13'd8));
    if (take) emit(s_word(5'd6, 12'(data_off)));
    store_expected(5'd5, 32'h0000_005a, 3'd4);
  endfunction

  function automatic void build_program();
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] here;
    a = 32'hfedc_b321;
    b = 32'h0001_2345;
    emit({20'h80000, 5'd10, 7'b0110111});                    // x10 data base
    emit(i_type(7'b0010011, 3'b000, 5'd10, 5'd10, 12'h400));
    emit({20'hfedcb, 5'd1, 7'b0110111});
    emit(i_type(7'b0010011, 3'b000, 5'd1, 5'd1, 12'h321));   // x1 negative
    emit({20'h00012, 5'd2, 7'b0110111});
    emit(i_type(7'b0010011, 3'b000, 5'd2, 5'd2, 12'h345));   // x2 positive
    emit(i_type(7'b0010011, 3'b000, 5'd3, 5'd0, 12'd5));
    emit(i_type(7'b0010011, 3'b000, 5'd5, 5'd0, 12'h05a));   // branch marker
    emit(i_type(7'b0010011, 3'b000, 5'd6, 5'd0, 12'hfff));   // poison value
    alu_rr(7'h00, 3'b000, 5'd1, 5'd2, a + b);
    alu_rr(7'h20, 3'b000, 5'd1, 5'd2, a - b);
    alu_rr(7'h00, 3'b100, 5'd1, 5'd2, a ^ b);
    alu_rr(7'h00, 3'b110, 5'd1, 5'd2, a | b);
    alu_rr(7'h00, 3'b111, 5'd1, 5'd2, a & b);
    alu_rr(7'h00, 3'b001, 5'd1, 5'd3, a << 5);
    alu_rr(7'h00, 3'b101, 5'd1, 5'd3, a >> 5);
    alu_rr(7'h20, 3'b101, 5'd1, 5'd3, (a >> 5) | 32'hf800_0000);  // a negative, ones shift in
    alu_rr(7'h00, 3'b010, 5'd1, 5'd2, 32'd1);
    alu_rr(7'h00, 3'b011, 5'd1, 5'd2, 32'd0);
    alu_rr(7'h00, 3'b010, 5'd2, 5'd1, 32'd0);
    alu_rr(7'h00, 3'b011, 5'd2, 5'd1, 32'd1);
    alu_ri(3'b000, 5'd1, 12'hff9, a - 32'd7);
    alu_ri(3'b100, 5'd1, 12'hff0, a ^ 32'hffff_fff0);
    alu_ri(3'b110, 5'd2, 12'h0f0, b | 32'h0000_00f0);
    alu_ri(3'b111, 5'd1, 12'h7ff, a & 32'h0000_07ff);
    alu_ri(3'b001, 5'd2, 12'h007, b << 7);
    alu_ri(3'b101, 5'd1, 12'h007, a >> 7);
    alu_ri(3'b101, 5'd1, 12'h407, (a >> 7) | 32'hfe00_0000);
    alu_ri(3'b010, 5'd1, 12'hfff, 32'd1);
    alu_ri(3'b011, 5'd2, 12'hfff, 32'd1);
    branch_case(3'b000, 5'd2, 5'd2, 1'b1);  // beq
    branch_case(3'b000, 5'd1, 5'd2, 1'b0);
    branch_case(3'b001, 5'd1, 5'd2, 1'b1);  // bne
    branch_case(3'b001, 5'd2, 5'd2, 1'b0);
    branch_case(3'b100, 5'd1, 5'd2, 1'b1);  // blt
    branch_case(3'b100, 5'd2, 5'd1, 1'b0);
    branch_case(3'b101, 5'd2, 5'd1, 1'b1);  // bge
    branch_case(3'b101, 5'd1, 5'd2, 1'b0);
    branch_case(3'b110, 5'd2, 5'd1, 1'b1);  // bltu
    branch_case(3'b110, 5'd1, 5'd2, 1'b0);
    branch_case(3'b111, 5'd1, 5'd2, 1'b1);  // bgeu
    branch_case(3'b111, 5'd2, 5'd1, 1'b0);
    emit({20'habcde, 5'd7, 7'b0110111});
    store_expected(5'd7, 32'habcd_e000, 3'd5);
    here = cur_pc();
    emit({20'h00012, 5'd7, 7'b0010111});                     // auipc
    store_expected(5'd7, here + 32'h0001_2000, 3'd5);
    here = cur_pc();
    emit(j_type(5'd8, 21'd8));
    emit(s_word(5'd6, 12'(data_off)));
    store_expected(5'd8, here + 32'd4, 3'd5);
    here = cur_pc();
    emit({20'h00000, 5'd9, 7'b0010111});
    emit(i_type(7'b1100111, 3'b000, 5'd8, 5'd9, 12'd17));   // odd target, bit 0 dropped
    emit(s_word(5'd6, 12'(data_off)));
    emit(s_word(5'd6, 12'(data_off)));
    store_expected(5'd8, here + 32'd8, 3'd5);
    emit(s_word(5'd1, 12'h1f0));
    expect_q.push_back('{addr: 32'h8000_05f0, data: a, group: 3'd6});
    emit(i_type(7'b0010011, 3'b000, 5'd11, 5'd10, 12'h100));
    emit(i_type(7'b0000011, 3'b010, 5'd12, 5'd11, 12'h0f0)); // lw x12
    emit(i_type(7'b0000011, 3'b010, 5'd0, 5'd11, 12'h0f0));
    emit(i_type(7'b0010011, 3'b000, 5'd0, 5'd2, 12'd1));
    store_expected(5'd12, a, 3'd6);
    store_expected(5'd0, 32'd0, 3'd6);
    emit(j_type(5'd0, 21'd0));  // halt loop
  endfunction

  task automatic report_test(input int g);
    tests_run++;
    if (group_err[g] == 0) begin
      $display("test %0d %s: ok", g, group_title(g));
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", g, group_title(g), group_err[g]);
    end
  endtask

  task automatic check_store(input logic [31:0] addr, input logic [31:0] data);
    store_t e;
    if (expect_q.size() == 0) begin
      err_count++;
      $display("store to %h with data %h was not expected", addr, data);
    end else begin
      e = expect_q.pop_front();
      assert (addr == e.addr && data == e.data) else begin
        err_count++;
        group_err[e.group]++;
        $display("[FAIL] %0t store %h to %h, expected %h to %h", $time, data, addr,
                 e.data, e.addr);
      end
      if (expect_q.size() == 0 || expect_q[0].group != e.group) report_test(int'(e.group));
    end
  endtask

  always @(posedge clk) begin
    if (arst_n && wr_valid) check_store(wr_addr, wr_data);
  end

  a_cmd_stable: assert property (@(posedge clk) disable iff (!arst_n)
      (mem_req && !mem_ack) |=> (cmd_bits == $past(cmd_bits))) else begin
    err_count++;
    group_err[2]++;
    $display("memory command changed while waiting for ack at %0t", $time);
  end

  a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
      $fell(mem_req) |-> $past(mem_ack)) else begin
    err_count++;
    group_err[2]++;
    $display("request dropped before ack at %0t", $time);
  end

  // ack seen low at the edge where req went up, a zero-wait ack may follow at once
  a_req_rise: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(mem_req) |-> !$past(mem_ack)) else begin
    err_count++;
    group_err[2]++;
    $display("request raised while ack was still high at %0t", $time);
  end

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // watchdog sized from program length
  initial begin
    wait (built);
    #((prog.size() * 20 + 200) * 20);
    $display("watchdog expired before all stores were seen");
    $display("Test failures found");
    $finish;
  end

  initial begin
    int n;
    arst_n       = 1'b0;
    built        = 1'b0;
    data_off     = 0;
    err_count    = 0;
    tests_run    = 0;
    tests_failed = 0;
    foreach (group_err[i]) group_err[i] = 0;
    build_program();
    built = 1'b1;
    @(posedge clk);
    for (int i = 0; i < prog.size(); i++) u_mem.load_word(i, prog[i]);
    repeat (15) @(posedge clk);
    assert (mem_req == 1'b0 && pc == 32'h8000_0000) else begin
      err_count++;
      group_err[1]++;
      $display("[FAIL] %0t during reset mem_req %b pc %h", $time, mem_req, pc);
    end
    #2 arst_n = 1'b1;
    n = 0;
    while (!mem_req && n < 10) begin
      @(negedge clk);  // away from the edge where req changes
      n++;
    end
    assert (mem_req && mem_cmd.addr == 32'h8000_0000 && !mem_cmd.write) else begin
      err_count++;
      group_err[1]++;
      $display("[FAIL] %0t first command addr %h write %b", $time, mem_cmd.addr,
               mem_cmd.write);
    end
    report_test(1);
    while (expect_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    report_test(2);
    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_count);
    if (err_count == 0 && tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

/* project.f */
source/rv_pkg.sv
source/rv_decoder.sv
source/rv_alu.sv
source/rv_regfile.sv
source/rv_sequencer.sv
source/rv_core.sv
bench/tb_mem_model.sv
bench/tb_rv_core.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the testbench with Verilator, verdict from the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f project.f --top-module tb_rv_core -o tb_rv_core \
  && ./obj_dir/tb_rv_core | tee sim.log \
  || { echo "build or simulation error"; exit 1; }

grep -q "All tests passed!" sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* source/rv_alu.sv */
`timescale 1ns/1ns

module rv_alu (
  input  rv_pkg::decoded_t        dec,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  output logic [rv_pkg::xlen-1:0] result,
  output logic                    taken
);

  localparam int msb = rv_pkg::xlen - 1;

  logic [msb:0] op_b;
  logic [msb:0] diff;
  logic         carry;  // no borrow when set
  logic         zero;
  logic         ovf;
  logic         lt;
  logic         ltu;
  logic [4:0]   shamt;

  assign op_b  = dec.use_imm ? dec.imm : rs2_data;
  assign shamt = op_b[4:0];

  // single subtractor feeds slt, sltu and every branch compare
  assign {carry, diff} = {1'b0, rs1_data} + {1'b0, ~op_b} + {{rv_pkg::xlen{1'b0}}, 1'b1};
  assign zero = (diff == '0);
  assign ovf  = (rs1_data[msb] != op_b[msb]) && (diff[msb] != rs1_data[msb]);
  assign lt   = diff[msb] ^ ovf;
  assign ltu  = ~carry;

  always_comb begin
    case (dec.alu_op)
      rv_pkg::alu_add:  result = rs1_data + op_b;  // also load/store address
      rv_pkg::alu_sub:  result = diff;
      rv_pkg::alu_xor:  result = rs1_data ^ op_b;
      rv_pkg::alu_or:   result = rs1_data | op_b;
      rv_pkg::alu_and:  result = rs1_data & op_b;
      rv_pkg::alu_sll:  result = rs1_data << shamt;
      rv_pkg::alu_srl:  result = rs1_data >> shamt;
      rv_pkg::alu_sra:  result = $unsigned($signed(rs1_data) >>> shamt);
      rv_pkg::alu_slt:  result = {{msb{1'b0}}, lt};
      rv_pkg::alu_sltu: result = {{msb{1'b0}}, ltu};
      default:          result = '0;
    endcase
  end

  always_comb begin
    taken = 1'b0;
    if (dec.kind == rv_pkg::kind_branch) begin
      case (dec.funct3)
        rv_pkg::f3_beq:  taken = zero;
        rv_pkg::f3_bne:  taken = ~zero;
        rv_pkg::f3_blt:  taken = lt;
        rv_pkg::f3_bge:  taken = ~lt;
        rv_pkg::f3_bltu: taken = ltu;
        rv_pkg::f3_bgeu: taken = ~ltu;
        default:         taken = 1'b0;  // reserved encodings
      endcase
    end
  end

endmodule

/* source/rv_core.sv */
`timescale 1ns/1ns

module rv_core (
  input  logic                    clk,
  input  logic                    arst_n,
  output logic                    mem_req,
  output rv_pkg::mem_cmd_t        mem_cmd,
  input  logic                    mem_ack,
  input  logic [rv_pkg::xlen-1:0] mem_rdata,
  output logic [rv_pkg::xlen-1:0] pc
);

  rv_pkg::decoded_t        dec;
  logic [rv_pkg::xlen-1:0] instr;
  logic [rv_pkg::xlen-1:0] rs1_data;
  logic [rv_pkg::xlen-1:0] rs2_data;
  logic [rv_pkg::xlen-1:0] alu_result;
  logic                    taken;
  logic                    rd_we;    // write-back port
  logic [4:0]              rd_addr;
  logic [rv_pkg::xlen-1:0] rd_data;

  rv_sequencer u_sequencer (
    .clk        (clk),
    .arst_n     (arst_n),
    .dec        (dec),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .alu_result (alu_result),
    .taken      (taken),
    .instr      (instr),
    .rd_we      (rd_we),
    .rd_addr    (rd_addr),
    .rd_data    (rd_data),
    .pc         (pc),
    .mem_req    (mem_req),
    .mem_cmd    (mem_cmd),
    .mem_ack    (mem_ack),
    .mem_rdata  (mem_rdata)
  );

  rv_decoder u_decoder (
    .instr (instr),
    .dec   (dec)
  );

  rv_alu u_alu (
    .dec      (dec),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (alu_result),
    .taken    (taken)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .arst_n   (arst_n),
    .rs1_addr (dec.rs1),
    .rs2_addr (dec.rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rd_we    (rd_we),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

/* source/rv_decoder.sv */
`timescale 1ns/1ns

module rv_decoder (
  input  logic [rv_pkg::xlen-1:0] instr,
  output rv_pkg::decoded_t        dec
);

  logic [6:0]              opcode;
  logic [2:0]              funct3;
  logic                    alt;     // instr[30], sub / sra select
  logic                    is_shift;
  logic [rv_pkg::xlen-1:0] imm_i;
  logic [rv_pkg::xlen-1:0] imm_s;
  logic [rv_pkg::xlen-1:0] imm_b;
  logic [rv_pkg::xlen-1:0] imm_u;
  logic [rv_pkg::xlen-1:0] imm_j;
  logic [rv_pkg::xlen-1:0] imm_sh;

  // funct3 to alu op, alt only matters for add/sub and srl/sra
  function automatic rv_pkg::alu_op_e alu_sel(input logic [2:0] f3, input logic sel_alt);
    rv_pkg::alu_op_e op;
    case (f3)
      rv_pkg::f3_add_sub: op = sel_alt ? rv_pkg::alu_sub : rv_pkg::alu_add;
      rv_pkg::f3_sll:     op = rv_pkg::alu_sll;
      rv_pkg::f3_slt:     op = rv_pkg::alu_slt;
      rv_pkg::f3_sltu:    op = rv_pkg::alu_sltu;
      rv_pkg::f3_xor:     op = rv_pkg::alu_xor;
      rv_pkg::f3_srl_sra: op = sel_alt ? rv_pkg::alu_sra : rv_pkg::alu_srl;
      rv_pkg::f3_or:      op = rv_pkg::alu_or;
      default:            op = rv_pkg::alu_and;
    endcase
    return op;
  endfunction

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign alt      = instr[30];
  assign is_shift = (funct3 == rv_pkg::f3_sll) || (funct3 == rv_pkg::f3_srl_sra);

  // immediate formats, sign from bit 31
  assign imm_i  = {{20{instr[31]}}, instr[31:20]};
  assign imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b  = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u  = {instr[31:12], 12'h000};
  assign imm_j  = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_sh = {27'd0, instr[24:20]};  // shamt only

  always_comb begin
    dec         = '0;
    dec.rs1     = instr[19:15];
    dec.rs2     = instr[24:20];
    dec.rd      = instr[11:7];
    dec.funct3  = funct3;
    dec.alu_op  = rv_pkg::alu_add;
    dec.use_imm = 1'b1;
    case (opcode)
      rv_pkg::op_reg: begin
        dec.kind    = rv_pkg::kind_reg;
        dec.use_imm = 1'b0;
        dec.alu_op  = alu_sel(funct3, alt);
      end
      rv_pkg::op_imm: begin
        dec.kind   = rv_pkg::kind_imm;
        dec.imm    = is_shift ? imm_sh : imm_i;
        // addi has no sub form, bit 30 only picks srai
        dec.alu_op = alu_sel(funct3, alt && (funct3 == rv_pkg::f3_srl_sra));
      end
      rv_pkg::op_load: begin
        dec.kind = rv_pkg::kind_load;
        dec.imm  = imm_i;
      end
      rv_pkg::op_store: begin
        dec.kind = rv_pkg::kind_store;
        dec.imm  = imm_s;
      end
      rv_pkg::op_branch: begin
        dec.kind    = rv_pkg::kind_branch;
        dec.imm     = imm_b;
        dec.use_imm = 1'b0;         // compare rs1 with rs2
        dec.alu_op  = rv_pkg::alu_sub;
      end
      rv_pkg::op_jal: begin
        dec.kind = rv_pkg::kind_jal;
        dec.imm  = imm_j;
      end
      rv_pkg::op_jalr: begin
        dec.kind = rv_pkg::kind_jalr;
        dec.imm  = imm_i;
      end
      rv_pkg::op_lui: begin
        dec.kind = rv_pkg::kind_lui;
        dec.imm  = imm_u;
      end
      rv_pkg::op_auipc: begin
        dec.kind = rv_pkg::kind_auipc;
        dec.imm  = imm_u;
      end
      default: dec.kind = rv_pkg::kind_illegal;
    endcase
  end

endmodule

/* source/rv_pkg.sv */
package rv_pkg;

  localparam int xlen = 32;

  localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

  // major opcodes
  localparam logic [6:0] op_reg    = 7'b011_0011;
  localparam logic [6:0] op_imm    = 7'b001_0011;
  localparam logic [6:0] op_load   = 7'b000_0011;
  localparam logic [6:0] op_store  = 7'b010_0011;
  localparam logic [6:0] op_branch = 7'b110_0011;
  localparam logic [6:0] op_jal    = 7'b110_1111;
  localparam logic [6:0] op_jalr   = 7'b110_0111;
  localparam logic [6:0] op_lui    = 7'b011_0111;
  localparam logic [6:0] op_auipc  = 7'b001_0111;

  // funct3, alu group (reg and imm forms share these)
  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // funct3, branch conditions
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  typedef enum logic [3:0] {
    kind_reg,
    kind_imm,
    kind_load,
    kind_store,
    kind_branch,
    kind_jal,
    kind_jalr,
    kind_lui,
    kind_auipc,
    kind_illegal  // retires as a no-op
  } instr_kind_e;

  typedef enum logic [3:0] {
    alu_add, alu_sub, alu_xor, alu_or, alu_and,
    alu_sll, alu_srl, alu_sra, alu_slt, alu_sltu
  } alu_op_e;

  typedef enum logic [2:0] {
    st_fetch,
    st_fetch_end,
    st_exec,
    st_mem,
    st_mem_end
  } seq_state_e;

  typedef struct packed {
    instr_kind_e      kind;
    logic [4:0]       rs1;
    logic [4:0]       rs2;
    logic [4:0]       rd;
    alu_op_e          alu_op;
    logic             use_imm;  // imm instead of rs2 as operand b
    logic [2:0]       funct3;   // branch condition
    logic [xlen-1:0]  imm;
  } decoded_t;

  typedef struct packed {
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic            write;
  } mem_cmd_t;

endpackage

/* source/rv_regfile.sv */
`timescale 1ns/1ns

module rv_regfile (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic [4:0]              rs1_addr,
  input  logic [4:0]              rs2_addr,
  output logic [rv_pkg::xlen-1:0] rs1_data,
  output logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic                    rd_we,
  input  logic [4:0]              rd_addr,
  input  logic [rv_pkg::xlen-1:0] rd_data
);

  logic [rv_pkg::xlen-1:0] regs [32];

  // x0 is cleared by reset and never written, so it reads as zero
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (rd_we && (rd_addr != 5'd0)) begin
      regs[rd_addr] <= rd_data;
    end
  end

  assign rs1_data = regs[rs1_addr];
  assign rs2_data = regs[rs2_addr];

endmodule

/* source/rv_sequencer.sv */
`timescale 1ns/1ns

module rv_sequencer (
  input  logic                    clk,
  input  logic                    arst_n,
  input  rv_pkg::decoded_t        dec,
  input  logic [rv_pkg::xlen-1:0] rs1_data,
  input  logic [rv_pkg::xlen-1:0] rs2_data,
  input  logic [rv_pkg::xlen-1:0] alu_result,
  input  logic                    taken,
  output logic [rv_pkg::xlen-1:0] instr,
  output logic                    rd_we,
  output logic [4:0]              rd_addr,
  output logic [rv_pkg::xlen-1:0] rd_data,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic                    mem_req,
  output rv_pkg::mem_cmd_t        mem_cmd,
  input  logic                    mem_ack,
  input  logic [rv_pkg::xlen-1:0] mem_rdata
);

  rv_pkg::seq_state_e      state;
  logic [rv_pkg::xlen-1:0] load_q;     // word returned by lw
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic [rv_pkg::xlen-1:0] pc_rel;     // pc + imm
  logic [rv_pkg::xlen-1:0] jalr_target;
  logic [rv_pkg::xlen-1:0] next_pc;
  logic                    is_mem;
  logic                    writes_reg;
  logic                    fetch_issue;
  logic                    fetch_done;
  logic                    mem_issue;
  logic                    load_take;
  logic                    mem_done;

  assign pc_plus4    = pc + rv_pkg::xlen'(4);
  assign pc_rel      = pc + dec.imm;
  assign jalr_target = (rs1_data + dec.imm) & ~rv_pkg::xlen'(1);
  assign is_mem      = (dec.kind == rv_pkg::kind_load) || (dec.kind == rv_pkg::kind_store);

  // handshake events
  assign fetch_issue = (state == rv_pkg::st_fetch) && !mem_req;
  assign fetch_done  = (state == rv_pkg::st_fetch) && mem_req && mem_ack;
  assign mem_issue   = (state == rv_pkg::st_exec) && is_mem;
  assign load_take   = (state == rv_pkg::st_mem) && mem_ack;
  assign mem_done    = (state == rv_pkg::st_mem_end) && !mem_ack;  // load/store retires

  // next pc and write-back select
  always_comb begin
    next_pc    = pc_plus4;
    writes_reg = 1'b0;
    rd_data    = alu_result;
    case (dec.kind)
      rv_pkg::kind_reg, rv_pkg::kind_imm: writes_reg = 1'b1;
      rv_pkg::kind_branch: if (taken) next_pc = pc_rel;
      rv_pkg::kind_jal: begin
        next_pc    = pc_rel;
        writes_reg = 1'b1;
        rd_data    = pc_plus4;
      end
      rv_pkg::kind_jalr: begin
        next_pc    = jalr_target;
        writes_reg = 1'b1;
        rd_data    = pc_plus4;
      end
      rv_pkg::kind_lui: begin
        writes_reg = 1'b1;
        rd_data    = dec.imm;
      end
      rv_pkg::kind_auipc: begin
        writes_reg = 1'b1;
        rd_data    = pc_rel;
      end
      rv_pkg::kind_load: rd_data = load_q;  // written in mem_end
      default: ;
    endcase
  end

  assign rd_we   = ((state == rv_pkg::st_exec) && writes_reg) ||
                   (mem_done && (dec.kind == rv_pkg::kind_load));
  assign rd_addr = dec.rd;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= rv_pkg::st_fetch;
      pc      <= rv_pkg::reset_vector;
      mem_req <= 1'b0;
    end else begin
      case (state)
        rv_pkg::st_fetch: begin
          if (fetch_issue) begin
            mem_req <= 1'b1;
          end else if (fetch_done) begin
            mem_req <= 1'b0;
            state   <= rv_pkg::st_fetch_end;
          end
        end
        rv_pkg::st_fetch_end: if (!mem_ack) state <= rv_pkg::st_exec;
        rv_pkg::st_exec: begin
          if (is_mem) begin
            mem_req <= 1'b1;  // ack has been low since fetch_end
            state   <= rv_pkg::st_mem;
          end else begin
            pc    <= next_pc;
            state <= rv_pkg::st_fetch;
          end
        end
        rv_pkg::st_mem: begin
          if (load_take) begin
            mem_req <= 1'b0;
            state   <= rv_pkg::st_mem_end;
          end
        end
        rv_pkg::st_mem_end: begin
          if (mem_done) begin
            pc    <= pc_plus4;
            state <= rv_pkg::st_fetch;
          end
        end
        default: state <= rv_pkg::st_fetch;
      endcase
    end
  end

  // command is loaded only when req rises, so it holds until ack
  always_ff @(posedge clk) begin
    if (fetch_issue) begin
      mem_cmd <= '{addr: {pc[rv_pkg::xlen-1:2], 2'b00}, wdata: '0, write: 1'b0};
    end else if (mem_issue) begin
      mem_cmd <= '{addr:  {alu_result[rv_pkg::xlen-1:2], 2'b00},
                   wdata: rs2_data,
                   write: (dec.kind == rv_pkg::kind_store)};
    end
    if (fetch_done) instr <= mem_rdata;
    if (load_take) load_q <= mem_rdata;
  end

endmodule
